// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = tb_top
FILELIST  = compile.f
OBJ_DIR   = obj_dir

SIM     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out=$$(./$(SIM)); \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** PASSED ***'

clean:
	rm -rf $(OBJ_DIR)

// ==== compile.f ====
rtl/soc_bus_pkg.sv
rtl/bus_region_decode.sv
rtl/onchip_mem.sv
rtl/key_irq_ctrl.sv
rtl/bus_read_result.sv
rtl/soc_bus_top.sv
test/tb_checker.sv
test/tb_top.sv

// ==== rtl/bus_read_result.sv ====
`timescale 1ns/1ps

module bus_read_result (
    input  logic                                   CLOCK_50,
    input  logic                                   KEY0,
    input  logic                                   bus_read_enable,
    input  logic                                   bus_write_enable,
    input  soc_bus_pkg::region_t                   region,
    input  logic [soc_bus_pkg::data_width-1:0]     bus_write_data,
    input  logic [soc_bus_pkg::mem_word_width-1:0] mem_read_word,
    input  logic [7:0]                             key_byte,
    output logic [soc_bus_pkg::data_width-1:0]     bus_read_data,
    output logic [7:0]                             uart_tx_data,
    output logic                                   uart_tx_strobe
);

    localparam int mem_pad = soc_bus_pkg::data_width - soc_bus_pkg::mem_word_width;
    localparam int key_pad = soc_bus_pkg::data_width - 8;

    // Read request delayed to line up with the memory output
    logic                 read_enable_q;
    soc_bus_pkg::region_t region_q;

    // Console write level and its previous value
    logic uart_write;
    logic uart_write_q;
    logic uart_write_rise;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            read_enable_q <= 1'b0;
            region_q      <= soc_bus_pkg::region_none;
        end else begin
            read_enable_q <= bus_read_enable;
            region_q      <= region;
        end
    end

    // Zero whenever the previous edge had no read
    always_comb begin
        bus_read_data = '0;
        if (read_enable_q) begin
            case (region_q)
                soc_bus_pkg::region_rom,
                soc_bus_pkg::region_ram: bus_read_data = {{mem_pad{1'b0}}, mem_read_word};
                soc_bus_pkg::region_key: bus_read_data = {{key_pad{1'b0}}, key_byte};
                // UART and unmapped reads give zero
                default: bus_read_data = '0;
            endcase
        end
    end

    assign uart_write      = bus_write_enable && (region == soc_bus_pkg::region_uart);
    // Only the first cycle of a held write counts
    assign uart_write_rise = uart_write && !uart_write_q;

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            uart_write_q   <= 1'b0;
            uart_tx_strobe <= 1'b0;
            uart_tx_data   <= 8'd0;
        end else begin
            uart_write_q   <= uart_write;
            uart_tx_strobe <= uart_write_rise;
            // Byte stays until the next console write
            if (uart_write_rise) begin
                uart_tx_data <= bus_write_data[7:0];
            end
        end
    end

endmodule

// ==== rtl/bus_region_decode.sv ====
`timescale 1ns/1ps

module bus_region_decode #(
    parameter int rom_words = 1024,
    parameter int ram_words = 1024
) (
    input  logic [soc_bus_pkg::addr_width-1:0]  bus_address,
    output soc_bus_pkg::region_t                region,
    output logic [$clog2(rom_words+ram_words)-1:0] word_index
);

    localparam int index_width = $clog2(rom_words + ram_words);

    // Offsets from each region base
    // Wraps to a huge value below the base, so one compare covers both bounds
    logic [soc_bus_pkg::addr_width-1:0] rom_offset;
    logic [soc_bus_pkg::addr_width-1:0] ram_offset;
    logic                               rom_hit;
    logic                               ram_hit;
    logic                               uart_hit;
    logic                               key_hit;

    assign rom_offset = bus_address - soc_bus_pkg::rom_base;
    assign ram_offset = bus_address - soc_bus_pkg::ram_base;

    assign rom_hit  = rom_offset < soc_bus_pkg::rom_size;
    assign ram_hit  = ram_offset < soc_bus_pkg::ram_size;
    assign uart_hit = bus_address == soc_bus_pkg::uart_addr;
    assign key_hit  = bus_address == soc_bus_pkg::key_addr;

    always_comb begin
        region     = soc_bus_pkg::region_none;
        word_index = '0;
        // Exact peripheral matches win over any range
        if (uart_hit) begin
            region = soc_bus_pkg::region_uart;
        end else if (key_hit) begin
            region = soc_bus_pkg::region_key;
        end else if (rom_hit) begin
            region     = soc_bus_pkg::region_rom;
            word_index = index_width'(rom_offset >> 2);
        end else if (ram_hit) begin
            region     = soc_bus_pkg::region_ram;
            // RAM words sit right after the ROM image in the shared array
            word_index = index_width'(rom_words) + index_width'(ram_offset >> 2);
        end
    end

endmodule

// ==== rtl/key_irq_ctrl.sv ====
`timescale 1ns/1ps

module key_irq_ctrl (
    input  logic       CLOCK_50,
    input  logic       KEY0,
    input  logic [7:0] key_ascii,
    input  logic       key_strobe,
    input  logic       interrupt_ack,
    output logic [7:0] key_byte,
    output logic [3:0] interrupt_vector
);

    soc_bus_pkg::irq_state_t irq_state;
    soc_bus_pkg::irq_state_t irq_state_next;

    // A strobe with a zero byte is not a key
    logic new_key;

    assign new_key = key_strobe && (key_ascii != 8'd0);

    // Last nonzero key byte
    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            key_byte <= 8'd0;
        end else if (new_key) begin
            key_byte <= key_ascii;
        end
    end

    // Acknowledge beats a key arriving on the same edge
    always_comb begin
        irq_state_next = irq_state;
        case (irq_state)
            soc_bus_pkg::irq_idle: begin
                if (new_key && !interrupt_ack) begin
                    irq_state_next = soc_bus_pkg::irq_pending;
                end
            end
            soc_bus_pkg::irq_pending: begin
                // Raised once per key, held until acknowledged
                if (interrupt_ack) begin
                    irq_state_next = soc_bus_pkg::irq_idle;
                end
            end
            default: begin
                irq_state_next = soc_bus_pkg::irq_idle;
            end
        endcase
    end

    always_ff @(posedge CLOCK_50 or negedge KEY0) begin
        if (!KEY0) begin
            irq_state <= soc_bus_pkg::irq_idle;
        end else begin
            irq_state <= irq_state_next;
        end
    end

    // Vector follows the registered state
    assign interrupt_vector = (irq_state == soc_bus_pkg::irq_pending) ?
                              soc_bus_pkg::irq_key_vector : 4'd0;

endmodule

// ==== rtl/onchip_mem.sv ====
`timescale 1ns/1ps

module onchip_mem #(
    parameter int rom_words = 1024,
    parameter int ram_words = 1024
) (
    input  logic                                   CLOCK_50,
    input  logic                                   bus_write_enable,
    input  soc_bus_pkg::region_t                   region,
    input  logic [$clog2(rom_words+ram_words)-1:0] word_index,
    input  logic [soc_bus_pkg::data_width-1:0]     bus_write_data,
    output logic [soc_bus_pkg::mem_word_width-1:0] mem_read_word
);

    localparam int mem_words = rom_words + ram_words;

    // ROM words first, then RAM words
    logic [soc_bus_pkg::mem_word_width-1:0] mem [0:mem_words-1];

    // Only writes aimed at RAM reach the array
    logic ram_write;

    // Boot image into the ROM part
    // RAM part stays undefined until the core writes it
    initial begin
        $readmemh("test/rom.hex", mem, 0);
    end

    assign ram_write = bus_write_enable && (region == soc_bus_pkg::region_ram);

    // Read-during-write returns the old word
    always_ff @(posedge CLOCK_50) begin
        if (ram_write) begin
            // Upper half of the 64-bit bus is dropped
            mem[word_index] <= bus_write_data[soc_bus_pkg::mem_word_width-1:0];
        end
        // Unconditional read, the result block decides if it is used
        mem_read_word <= mem[word_index];
    end

endmodule

// ==== rtl/soc_bus_pkg.sv ====
package soc_bus_pkg;

    // Core bus widths, one word each
    localparam int addr_width = 64;
    localparam int data_width = 64;

    // On-chip memory stores 32-bit words
    localparam int mem_word_width = 32;

    // Memory regions, byte addresses
    localparam logic [addr_width-1:0] rom_base = 64'h0000_0000_0000_0000;
    localparam logic [addr_width-1:0] rom_size = 64'h0000_0000_0000_1000;
    localparam logic [addr_width-1:0] ram_base = 64'h0000_0000_0000_1000;
    localparam logic [addr_width-1:0] ram_size = 64'h0000_0000_0000_1000;

    // Single-address peripheral registers
    // Console data register
    localparam logic [addr_width-1:0] uart_addr = 64'h0000_0000_0000_2000;
    // Last key byte
    localparam logic [addr_width-1:0] key_addr = 64'h0000_0000_0000_2008;

    // Decoded bus target
    typedef enum logic [2:0] {
        region_none,
        region_rom,
        region_ram,
        region_uart,
        region_key
    } region_t;

    // Key interrupt request state
    typedef enum logic {
        irq_idle,
        irq_pending
    } irq_state_t;

    // Vector shown to the core while a key interrupt waits
    localparam logic [3:0] irq_key_vector = 4'd1;

endpackage

// ==== rtl/soc_bus_top.sv ====
`timescale 1ns/1ps

module soc_bus_top #(
    parameter int rom_words = 1024,
    parameter int ram_words = 1024
) (
    input  logic                               CLOCK_50,
    input  logic                               KEY0,

    // Core data bus
    input  logic [soc_bus_pkg::addr_width-1:0] bus_address,
    input  logic [soc_bus_pkg::data_width-1:0] bus_write_data,
    input  logic                               bus_write_enable,
    input  logic                               bus_read_enable,
    output logic [soc_bus_pkg::data_width-1:0] bus_read_data,

    // Decoded keyboard byte
    input  logic [7:0]                         key_ascii,
    input  logic                               key_strobe,

    // Console byte out
    output logic [7:0]                         uart_tx_data,
    output logic                               uart_tx_strobe,

    // Interrupt to the core and its acknowledge
    output logic [3:0]                         interrupt_vector,
    input  logic                               interrupt_ack
);

    localparam int index_width = $clog2(rom_words + ram_words);

    soc_bus_pkg::region_t                   region;
    logic [index_width-1:0]                 word_index;
    logic [soc_bus_pkg::mem_word_width-1:0] mem_read_word;
    logic [7:0]                             key_byte;

    // Address to region and memory word
    bus_region_decode #(
        .rom_words (rom_words),
        .ram_words (ram_words)
    ) decode0 (
        .bus_address (bus_address),
        .region      (region),
        .word_index  (word_index)
    );

    // ROM image plus RAM in one array
    onchip_mem #(
        .rom_words (rom_words),
        .ram_words (ram_words)
    ) mem0 (
        .CLOCK_50         (CLOCK_50),
        .bus_write_enable (bus_write_enable),
        .region           (region),
        .word_index       (word_index),
        .bus_write_data   (bus_write_data),
        .mem_read_word    (mem_read_word)
    );

    key_irq_ctrl key0 (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .key_ascii        (key_ascii),
        .key_strobe       (key_strobe),
        .interrupt_ack    (interrupt_ack),
        .key_byte         (key_byte),
        .interrupt_vector (interrupt_vector)
    );

    // Read mux and console strobe
    bus_read_result result0 (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_read_enable  (bus_read_enable),
        .bus_write_enable (bus_write_enable),
        .region           (region),
        .bus_write_data   (bus_write_data),
        .mem_read_word    (mem_read_word),
        .key_byte         (key_byte),
        .bus_read_data    (bus_read_data),
        .uart_tx_data     (uart_tx_data),
        .uart_tx_strobe   (uart_tx_strobe)
    );

endmodule

// ==== test/rom.hex ====
// One 32-bit ROM word per line in hex, word 0 first
// Loaded into words 0 to 15 of the ROM region
00000013
00001137
0ff00093
12345678
89abcdef
deadbeef
cafef00d
0badc0de
13579bdf
2468ace0
fedcba98
76543210
a5a5a5a5
5a5a5a5a
00000073
ffffffff

// ==== test/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker (
    input logic        CLOCK_50,
    input logic        KEY0,
    input logic [63:0] bus_address,
    input logic [63:0] bus_write_data,
    input logic        bus_write_enable,
    input logic        bus_read_enable,
    input logic [63:0] bus_read_data,
    input logic [7:0]  key_ascii,
    input logic        key_strobe,
    input logic [7:0]  uart_tx_data,
    input logic        uart_tx_strobe,
    input logic [3:0]  interrupt_vector,
    input logic        interrupt_ack
);

    // Reference copies of ROM image and RAM
    logic [31:0] rom_image [0:15];
    logic [31:0] ram_model [0:1023];
    logic        ram_known [0:1023];

    // Expected outputs after the latest edge
    logic [63:0] exp_read_data;
    logic        exp_read_known;
    logic [7:0]  exp_tx_data;
    logic        exp_tx_strobe;
    logic        uart_prev;
    logic [7:0]  key_model;
    logic        irq_pending;

    int check_count;
    int error_count;

    initial begin
        $readmemh("test/rom.hex", rom_image);
        for (int i = 0; i < 1024; i++) begin
            ram_known[i] = 1'b0;
        end
        check_count    = 0;
        error_count    = 0;
        exp_read_data  = 64'd0;
        exp_read_known = 1'b1;
        exp_tx_data    = 8'd0;
        exp_tx_strobe  = 1'b0;
        uart_prev      = 1'b0;
        key_model      = 8'd0;
        irq_pending    = 1'b0;
    end

    // Address map as the bus rules give it
    function automatic soc_bus_pkg::region_t region_of(input logic [63:0] addr);
        if (addr == 64'h2000) begin
            return soc_bus_pkg::region_uart;
        end else if (addr == 64'h2008) begin
            return soc_bus_pkg::region_key;
        end else if (addr < 64'h1000) begin
            return soc_bus_pkg::region_rom;
        end else if (addr < 64'h2000) begin
            return soc_bus_pkg::region_ram;
        end
        return soc_bus_pkg::region_none;
    endfunction

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("ERROR %s got %h expected %h at %0t", name, got, exp, $time);
        end else begin
            check_count++;
        end
    endtask

    // Model steps on the same edges as the DUT
    always @(posedge CLOCK_50 or negedge KEY0) begin : model_step
        soc_bus_pkg::region_t target;
        logic [9:0]           idx;
        logic                 new_key;
        logic                 uart_write;
        if (!KEY0) begin
            exp_read_data  = 64'd0;
            exp_read_known = 1'b1;
            exp_tx_data    = 8'd0;
            exp_tx_strobe  = 1'b0;
            uart_prev      = 1'b0;
            key_model      = 8'd0;
            irq_pending    = 1'b0;
        end else begin
            target  = region_of(bus_address);
            idx     = bus_address[11:2];
            // Key byte first, a key read sees the new byte
            new_key = key_strobe && (key_ascii != 8'd0);
            if (new_key) begin
                key_model = key_ascii;
            end
            // Ack wins over a key on the same edge
            if (irq_pending && interrupt_ack) begin
                irq_pending = 1'b0;
            end else if (!irq_pending && new_key && !interrupt_ack) begin
                irq_pending = 1'b1;
            end
            // Read before write, old word on a clash
            exp_read_data  = 64'd0;
            exp_read_known = 1'b1;
            if (bus_read_enable) begin
                case (target)
                    soc_bus_pkg::region_rom: begin
                        if (idx < 10'd16) begin
                            exp_read_data = {32'd0, rom_image[idx[3:0]]};
                        end else begin
                            exp_read_known = 1'b0;
                        end
                    end
                    soc_bus_pkg::region_ram: begin
                        exp_read_data  = {32'd0, ram_model[idx]};
                        exp_read_known = ram_known[idx];
                    end
                    soc_bus_pkg::region_key: exp_read_data = {56'd0, key_model};
                    default: exp_read_data = 64'd0;
                endcase
            end
            if (bus_write_enable && target == soc_bus_pkg::region_ram) begin
                ram_model[idx] = bus_write_data[31:0];
                ram_known[idx] = 1'b1;
            end
            // One strobe per start of a console write
            uart_write    = bus_write_enable && (target == soc_bus_pkg::region_uart);
            exp_tx_strobe = uart_write && !uart_prev;
            if (exp_tx_strobe) begin
                exp_tx_data = bus_write_data[7:0];
            end
            uart_prev = uart_write;
        end
    end

    // Outputs are settled mid-cycle
    always @(negedge CLOCK_50) begin
        if (exp_read_known) begin
            compare_value("bus_read_data", bus_read_data, exp_read_data);
        end
        if (uart_tx_strobe !== exp_tx_strobe) begin
            error_count++;
            if (exp_tx_strobe) begin
                $display("uart_tx_strobe missing after a console write at %0t", $time);
            end else begin
                $display("extra uart_tx_strobe with no new console write at %0t", $time);
            end
        end else begin
            check_count++;
        end
        compare_value("uart_tx_data", {56'd0, uart_tx_data}, {56'd0, exp_tx_data});
        compare_value("interrupt_vector", {60'd0, interrupt_vector},
                      irq_pending ? 64'd1 : 64'd0);
    end

endmodule

// ==== test/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

    localparam int clock_period = 40;
    localparam int max_entries  = 128;

    typedef enum {
        op_idle,
        op_read,
        op_write,
        op_rdwr,
        op_key,
        op_ack,
        op_key_ack,
        op_reset
    } op_t;

    logic        CLOCK_50;
    logic        KEY0;
    logic [63:0] bus_address;
    logic [63:0] bus_write_data;
    logic        bus_write_enable;
    logic        bus_read_enable;
    logic [63:0] bus_read_data;
    logic [7:0]  key_ascii;
    logic        key_strobe;
    logic [7:0]  uart_tx_data;
    logic        uart_tx_strobe;
    logic [3:0]  interrupt_vector;
    logic        interrupt_ack;

    // Stimulus table
    op_t         table_op   [max_entries];
    logic [63:0] table_addr [max_entries];
    logic [63:0] table_data [max_entries];
    string       table_name [max_entries];
    int          entry_count;
    logic        table_ready;
    logic [31:0] lcg_state;
    int          tests_passed;
    int          tests_failed;

    soc_bus_top #(
        .rom_words (1024),
        .ram_words (1024)
    ) dut0 (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .key_ascii        (key_ascii),
        .key_strobe       (key_strobe),
        .uart_tx_data     (uart_tx_data),
        .uart_tx_strobe   (uart_tx_strobe),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack)
    );

    tb_checker chk0 (
        .CLOCK_50         (CLOCK_50),
        .KEY0             (KEY0),
        .bus_address      (bus_address),
        .bus_write_data   (bus_write_data),
        .bus_write_enable (bus_write_enable),
        .bus_read_enable  (bus_read_enable),
        .bus_read_data    (bus_read_data),
        .key_ascii        (key_ascii),
        .key_strobe       (key_strobe),
        .uart_tx_data     (uart_tx_data),
        .uart_tx_strobe   (uart_tx_strobe),
        .interrupt_vector (interrupt_vector),
        .interrupt_ack    (interrupt_ack)
    );

    always #(clock_period / 2) CLOCK_50 = ~CLOCK_50;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic add_entry(input op_t op, input logic [63:0] addr,
                             input logic [63:0] data, input string name);
        table_op[entry_count]   = op;
        table_addr[entry_count] = addr;
        table_data[entry_count] = data;
        table_name[entry_count] = name;
        entry_count++;
    endtask

    task automatic build_table();
        // Whole ROM image, then a write that must not stick
        for (int i = 0; i < 16; i++) begin
            add_entry(op_read, 64'(i * 4), 64'd0, "rom_read");
        end
        add_entry(op_write, 64'h8, 64'hffff_0000_dead_beef, "rom_read");
        add_entry(op_read, 64'h8, 64'd0, "rom_read");
        // RAM sweep with the upper data half dropped
        for (int i = 0; i < 16; i++) begin
            add_entry(op_write, 64'h1000 + 64'(i * 4), {lcg_next(), lcg_next()}, "ram_sweep");
        end
        for (int i = 0; i < 16; i++) begin
            add_entry(op_read, 64'h1000 + 64'(i * 4), 64'd0, "ram_sweep");
        end
        add_entry(op_rdwr, 64'h1010, {32'd0, lcg_next()}, "ram_sweep");
        add_entry(op_read, 64'h1010, 64'd0, "ram_sweep");
        // UART, gap and unmapped reads
        add_entry(op_read, 64'h2000, 64'd0, "zero_reads");
        add_entry(op_read, 64'h2004, 64'd0, "zero_reads");
        add_entry(op_read, 64'h3000, 64'd0, "zero_reads");
        add_entry(op_idle, 64'd0, 64'd0, "zero_reads");
        add_entry(op_idle, 64'd0, 64'd0, "zero_reads");
        // Held write, then two separate writes
        for (int i = 0; i < 3; i++) begin
            add_entry(op_write, 64'h2000, 64'h41, "uart_strobe");
        end
        add_entry(op_idle, 64'd0, 64'd0, "uart_strobe");
        add_entry(op_write, 64'h2000, 64'h142, "uart_strobe");
        add_entry(op_idle, 64'd0, 64'd0, "uart_strobe");
        add_entry(op_write, 64'h2000, 64'h43, "uart_strobe");
        // Key, zero strobe, ack, ack with a new key
        add_entry(op_key, 64'd0, 64'h61, "key_irq");
        add_entry(op_read, 64'h2008, 64'd0, "key_irq");
        add_entry(op_key, 64'd0, 64'h00, "key_irq");
        add_entry(op_read, 64'h2008, 64'd0, "key_irq");
        add_entry(op_ack, 64'd0, 64'd0, "key_irq");
        add_entry(op_idle, 64'd0, 64'd0, "key_irq");
        add_entry(op_key_ack, 64'd0, 64'h62, "key_irq");
        add_entry(op_idle, 64'd0, 64'd0, "key_irq");
        add_entry(op_read, 64'h2008, 64'd0, "key_irq");
        // Reset hits a pending key, a held console byte and a read result
        add_entry(op_key, 64'd0, 64'h63, "reset_values");
        add_entry(op_write, 64'h2000, 64'h5a, "reset_values");
        add_entry(op_read, 64'h2008, 64'd0, "reset_values");
        for (int i = 0; i < 3; i++) begin
            add_entry(op_reset, 64'd0, 64'd0, "reset_values");
        end
        // Key byte back to zero
        add_entry(op_read, 64'h2008, 64'd0, "reset_values");
    endtask

    // All inputs inactive unless the op sets them
    task automatic drive_entry(input op_t op, input logic [63:0] addr,
                               input logic [63:0] data);
        KEY0             = (op == op_reset) ? 1'b0 : 1'b1;
        bus_address      = addr;
        bus_write_data   = data;
        bus_write_enable = 1'b0;
        bus_read_enable  = 1'b0;
        key_ascii        = 8'd0;
        key_strobe       = 1'b0;
        interrupt_ack    = 1'b0;
        case (op)
            op_read:  bus_read_enable = 1'b1;
            op_write: bus_write_enable = 1'b1;
            op_rdwr: begin
                bus_read_enable  = 1'b1;
                bus_write_enable = 1'b1;
            end
            op_key: begin
                key_ascii  = data[7:0];
                key_strobe = 1'b1;
            end
            op_ack:   interrupt_ack = 1'b1;
            op_key_ack: begin
                key_ascii     = data[7:0];
                key_strobe    = 1'b1;
                interrupt_ack = 1'b1;
            end
            default: ;
        endcase
    endtask

    // One idle cycle lets the last result land
    task automatic finish_test(input string name, inout int errors_before);
        int errors_now;
        @(posedge CLOCK_50);
        #2;
        drive_entry(op_idle, 64'd0, 64'd0);
        @(negedge CLOCK_50);
        #1;
        errors_now = chk0.error_count - errors_before;
        errors_before = chk0.error_count;
        if (errors_now == 0) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors_now);
        end
    endtask

    initial begin
        int errors_before;
        CLOCK_50     = 1'b0;
        KEY0         = 1'b0;
        table_ready  = 1'b0;
        entry_count  = 0;
        tests_passed = 0;
        tests_failed = 0;
        lcg_state    = 32'h6b2;
        drive_entry(op_reset, 64'd0, 64'd0);
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge CLOCK_50);
        #2;
        KEY0 = 1'b1;
        errors_before = 0;
        for (int i = 0; i < entry_count; i++) begin
            @(posedge CLOCK_50);
            #2;
            drive_entry(table_op[i], table_addr[i], table_data[i]);
            if (i == entry_count - 1 || table_name[i + 1] != table_name[i]) begin
                finish_test(table_name[i], errors_before);
            end
        end
        $display("tests %0d passed %0d failed, checks %0d passed %0d failed",
                 tests_passed, tests_failed, chk0.check_count, chk0.error_count);
        if (chk0.error_count == 0 && tests_failed == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // Each entry takes at most two cycles, plus reset and margin
    initial begin
        wait (table_ready);
        #((entry_count * 2 + 20) * clock_period);
        $display("timeout, the stimulus table did not finish in time");
        $display("*** FAILED ***");
        $finish;
    end

endmodule
